/* common/img_ctrl_pkg.sv */
package img_ctrl_pkg;

    // ======================================================================
    // Image geometry and stream layout
    // ======================================================================
    localparam int img_width           = 16;
    localparam int img_height          = 16;
    localparam int img_pixel_count     = img_width * img_height;
    localparam int header_word_count   = 8;
    localparam int checksum_word_count = 2;
    localparam int padding_word_count  = 4;

    // Statistics are taken on a coarse grid of the frame
    localparam int stat_sample_period = 4;

    // Thumbnail keeps the top-left 2x2 corner of every 8x8 group
    localparam int thumb_group = 8;
    localparam int thumb_keep  = 2;

    // ======================================================================
    // Vector types
    // ======================================================================
    typedef logic [11:0]                       pixel_t;
    typedef logic [15:0]                       word_t;
    typedef logic [7:0]                        buf_addr_t;
    typedef logic [8:0]                        pixel_count_t;
    typedef logic [8:0]                        stat_count_t;
    typedef logic [header_word_count*16-1:0]   header_t;
    typedef logic [checksum_word_count*16-1:0] checksum_t;

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait_frame,
        cap_skip_check,
        cap_capture
    } capture_state_t;

    typedef enum logic [2:0] {
        ro_idle,
        ro_header,
        ro_pixels,
        ro_drain,
        ro_checksum,
        ro_padding,
        ro_done
    } readout_state_t;

endpackage

/* capture/pixel_capture.sv */
module pixel_capture (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_capture,
    input  logic                       cmd_skip_count,
    input  img_ctrl_pkg::pixel_t       img_d,
    input  logic                       img_fv,
    input  logic                       img_lv,
    output logic                       wr_en,
    output img_ctrl_pkg::buf_addr_t    wr_addr,
    output img_ctrl_pkg::word_t        wr_data,
    output logic                       capture_done,
    output img_ctrl_pkg::pixel_count_t pixel_count,
    output img_ctrl_pkg::stat_count_t  highlight_count,
    output img_ctrl_pkg::stat_count_t  shadow_count
);
    import img_ctrl_pkg::*;

    capture_state_t state;
    pixel_t d_q;
    pixel_t stat_px;
    logic fv_q;
    logic lv_q;
    logic fv_prev;
    logic lv_prev;
    logic frame_start;
    logic skip_count;
    logic stat_en;
    logic [$clog2(img_width)-1:0]  col;
    logic [$clog2(img_height)-1:0] row;

    assign frame_start = fv_q && !fv_prev;

    // Sensor input registers
    always_ff @(posedge clk) begin
        d_q <= img_d;
        if (reset) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            fv_prev <= fv_q;
            lv_prev <= lv_q;
        end
    end

    // Position inside the frame, used for the statistics grid
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else begin
            if (!lv_q) col <= '0;
            else       col <= col + 1'b1;

            if (!fv_q)                  row <= '0;
            else if (lv_prev && !lv_q)  row <= row + 1'b1;
        end
    end

    // ======================================================================
    // Capture FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        // Little endian: low 8 bits go first on the wire
        wr_data <= {d_q[7:0], 4'b0000, d_q[11:8]};
        stat_px <= d_q;

        if (reset) begin
            state           <= cap_idle;
            wr_en           <= 1'b0;
            wr_addr         <= '0;
            capture_done    <= 1'b0;
            stat_en         <= 1'b0;
            skip_count      <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            wr_en        <= 1'b0;
            capture_done <= 1'b0;
            stat_en      <= 1'b0;

            if (wr_en) begin
                wr_addr     <= wr_addr + 1'b1;
                pixel_count <= pixel_count + 1'b1;
            end

            // Top 7 bits decide highlight or shadow
            if (stat_en) begin
                if (&stat_px[11:5])       highlight_count <= highlight_count + 1'b1;
                else if (~|stat_px[11:5]) shadow_count <= shadow_count + 1'b1;
            end

            case (state)
                cap_wait_frame: begin
                    if (frame_start) state <= cap_skip_check;
                end

                cap_skip_check: begin
                    skip_count <= skip_count - 1'b1;
                    if (skip_count) state <= cap_wait_frame;
                    else            state <= cap_capture;
                end

                cap_capture: begin
                    wr_en   <= lv_q;
                    stat_en <= lv_q && (col % stat_sample_period == 0)
                                    && (row % stat_sample_period == 0);
                    if (!fv_q) begin
                        capture_done <= 1'b1;
                        state        <= cap_idle;
                    end
                end

                default: ;
            endcase

            // A new command restarts the capture from scratch
            if (cmd_capture) begin
                state           <= cap_wait_frame;
                skip_count      <= cmd_skip_count;
                wr_en           <= 1'b0;
                stat_en         <= 1'b0;
                wr_addr         <= '0;
                pixel_count     <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end
        end
    end

    a_write_in_capture: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> state == cap_capture
    );

endmodule

/* hdl/frame_buffer.sv */
module frame_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  img_ctrl_pkg::buf_addr_t wr_addr,
    input  img_ctrl_pkg::word_t     wr_data,
    input  logic                    rd_start,
    input  logic                    rd_take,
    output logic                    rd_valid,
    output img_ctrl_pkg::word_t     rd_data
);
    import img_ctrl_pkg::*;

    word_t mem [img_pixel_count];
    buf_addr_t rd_addr;
    buf_addr_t rd_addr_next;
    pixel_count_t remaining;

    assign rd_valid = (remaining != 0);

    // Rewind wins over a take in the same cycle
    always_comb begin
        if (rd_start)     rd_addr_next = '0;
        else if (rd_take) rd_addr_next = rd_addr + 1'b1;
        else              rd_addr_next = rd_addr;
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr_next];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_addr   <= '0;
            remaining <= '0;
        end else begin
            rd_addr <= rd_addr_next;
            if (rd_start)     remaining <= pixel_count_t'(img_pixel_count);
            else if (rd_take) remaining <= remaining - 1'b1;
        end
    end

    a_take_when_valid: assert property (
        @(posedge clk) disable iff (reset) rd_take |-> rd_valid
    );

endmodule

/* hdl/fletcher_checksum.sv */
module fletcher_checksum (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sum_clear,
    input  logic                    sum_en,
    input  img_ctrl_pkg::word_t     din,
    output img_ctrl_pkg::checksum_t sum
);
    import img_ctrl_pkg::*;

    word_t sum1;
    word_t sum2;
    word_t sum1_next;

    // Addition modulo 65535
    function automatic word_t mod_add(word_t a, word_t b);
        logic [16:0] t;
        t = a + b;
        if (t >= 17'd65535) t = t - 17'd65535;
        return t[15:0];
    endfunction

    // Words are summed as the host sees them, byte swapped
    assign sum1_next = mod_add(sum1, {din[7:0], din[15:8]});
    assign sum = {sum2, sum1};

    always_ff @(posedge clk) begin
        if (reset || sum_clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (sum_en) begin
            sum1 <= sum1_next;
            sum2 <= mod_add(sum2, sum1_next);
        end
    end

endmodule

/* readout/readout_sequencer.sv */
module readout_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_readout,
    input  img_ctrl_pkg::header_t   cmd_header,
    input  logic                    cmd_thumb,
    input  logic                    rd_valid,
    input  img_ctrl_pkg::word_t     rd_data,
    input  img_ctrl_pkg::checksum_t sum,
    input  logic                    readout_trigger,
    output logic                    rd_start,
    output logic                    rd_take,
    output logic                    sum_clear,
    output logic                    sum_en,
    output logic                    readout_start,
    output logic                    readout_ready,
    output img_ctrl_pkg::word_t     readout_data,
    output logic                    readout_done
);
    import img_ctrl_pkg::*;

    readout_state_t state;
    header_t shift_data;
    logic [3:0] word_count;
    logic thumb_en;
    logic [$clog2(img_width)-1:0]  col;
    logic [$clog2(img_height)-1:0] row;
    logic data_load;
    logic shift_load;
    logic pixel_keep;

    // Output register is free when empty or drained this cycle
    assign data_load  = !readout_ready || readout_trigger;
    assign shift_load = data_load && (word_count != 0);
    assign rd_take    = (state == ro_pixels) && rd_valid && data_load;

    assign pixel_keep = !thumb_en || (((col % thumb_group) < thumb_keep)
                                   && ((row % thumb_group) < thumb_keep));

    // Pixel position of the word on rd_data
    always_ff @(posedge clk) begin
        if (reset || cmd_readout) begin
            col <= '0;
            row <= '0;
        end else if (rd_take) begin
            col <= col + 1'b1;
            if (col == img_width - 1) row <= row + 1'b1;
        end
    end

    // ======================================================================
    // Readout FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ro_idle;
            word_count    <= '0;
            thumb_en      <= 1'b0;
            rd_start      <= 1'b0;
            sum_clear     <= 1'b0;
            sum_en        <= 1'b0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            readout_done  <= 1'b0;
        end else begin
            rd_start      <= 1'b0;
            sum_clear     <= 1'b0;
            sum_en        <= 1'b0;
            readout_start <= 1'b0;
            if (readout_trigger) readout_ready <= 1'b0;

            // Header, checksum and padding all leave MSW first from shift_data
            if (shift_load && (state == ro_header || state == ro_checksum
                               || state == ro_padding)) begin
                readout_data  <= shift_data[$bits(header_t)-1 -: 16];
                shift_data    <= shift_data << 16;
                word_count    <= word_count - 1'b1;
                readout_ready <= 1'b1;
                sum_en        <= (state == ro_header);
            end

            case (state)
                ro_header: begin
                    if (word_count == 0) state <= ro_pixels;
                end

                ro_pixels: begin
                    if (!rd_valid) begin
                        state <= ro_drain;
                    end else if (rd_take && pixel_keep) begin
                        readout_data  <= rd_data;
                        readout_ready <= 1'b1;
                        sum_en        <= 1'b1;
                    end
                end

                // Hold until no checksum update is in flight
                ro_drain: begin
                    if (!sum_en) begin
                        shift_data <= {sum[7:0], sum[15:8], sum[23:16], sum[31:24],
                                       {($bits(header_t)-32){1'b0}}};
                        word_count <= 4'(checksum_word_count);
                        state      <= ro_checksum;
                    end
                end

                ro_checksum: begin
                    if (word_count == 0) begin
                        word_count <= 4'(padding_word_count);
                        state      <= ro_padding;
                    end
                end

                // Done only once the last zero word has been taken
                ro_padding: begin
                    if (word_count == 0 && readout_ready && readout_trigger) begin
                        readout_done <= 1'b1;
                        state        <= ro_done;
                    end
                end

                default: ;
            endcase

            if (cmd_readout) begin
                state         <= ro_header;
                shift_data    <= cmd_header;
                word_count    <= 4'(header_word_count);
                thumb_en      <= cmd_thumb;
                rd_start      <= 1'b1;
                sum_clear     <= 1'b1;
                sum_en        <= 1'b0;
                readout_start <= 1'b1;
                readout_ready <= 1'b0;
                readout_done  <= 1'b0;
            end
        end
    end

    a_data_held: assert property (
        @(posedge clk) disable iff (reset)
        (readout_ready && !readout_trigger) |=> $stable(readout_data)
    );

endmodule

/* hdl/img_controller.sv */
module img_controller (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_capture,
    input  logic                       cmd_skip_count,
    input  logic                       cmd_readout,
    input  img_ctrl_pkg::header_t      cmd_header,
    input  logic                       cmd_thumb,
    input  img_ctrl_pkg::pixel_t       img_d,
    input  logic                       img_fv,
    input  logic                       img_lv,
    input  logic                       readout_trigger,
    output logic                       status_capture_done,
    output img_ctrl_pkg::pixel_count_t status_pixel_count,
    output img_ctrl_pkg::stat_count_t  status_highlight_count,
    output img_ctrl_pkg::stat_count_t  status_shadow_count,
    output logic                       readout_start,
    output logic                       readout_ready,
    output img_ctrl_pkg::word_t        readout_data,
    output logic                       readout_done
);
    import img_ctrl_pkg::*;

    // Capture to buffer
    logic      wr_en;
    buf_addr_t wr_addr;
    word_t     wr_data;

    // Buffer to readout
    logic      rd_start;
    logic      rd_take;
    logic      rd_valid;
    word_t     rd_data;

    // Checksum
    logic      sum_clear;
    logic      sum_en;
    checksum_t sum;

    pixel_capture capture_i (
        .clk             (clk),
        .reset           (reset),
        .cmd_capture     (cmd_capture),
        .cmd_skip_count  (cmd_skip_count),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .capture_done    (status_capture_done),
        .pixel_count     (status_pixel_count),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    frame_buffer buffer_i (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_start (rd_start),
        .rd_take  (rd_take),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    fletcher_checksum checksum_i (
        .clk       (clk),
        .reset     (reset),
        .sum_clear (sum_clear),
        .sum_en    (sum_en),
        .din       (readout_data),
        .sum       (sum)
    );

    readout_sequencer sequencer_i (
        .clk             (clk),
        .reset           (reset),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .rd_valid        (rd_valid),
        .rd_data         (rd_data),
        .sum             (sum),
        .readout_trigger (readout_trigger),
        .rd_start        (rd_start),
        .rd_take         (rd_take),
        .sum_clear       (sum_clear),
        .sum_en          (sum_en),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_done    (readout_done)
    );

endmodule

/* testbench/tb_img_controller.sv */
module tb_img_controller;
    timeunit 1ns;
    timeprecision 1ps;

    import img_ctrl_pkg::*;

    localparam int clk_period     = 40;
    localparam int frame_cycles   = 16 + img_height * (img_width + 4);
    localparam int stream_words   = header_word_count + img_pixel_count
                                    + checksum_word_count + padding_word_count;
    localparam int readout_cycles = 2 * stream_words + 16;
    // Three frames and four readouts, with a margin of four
    localparam int watchdog_cycles = 4 * (8 + 3 * frame_cycles + 4 * 4 * readout_cycles);

    logic         clk;
    logic         reset;
    logic         cmd_capture;
    logic         cmd_skip_count;
    logic         cmd_readout;
    header_t      cmd_header;
    logic         cmd_thumb;
    pixel_t       img_d;
    logic         img_fv;
    logic         img_lv;
    logic         readout_trigger;
    logic         status_capture_done;
    pixel_count_t status_pixel_count;
    stat_count_t  status_highlight_count;
    stat_count_t  status_shadow_count;
    logic         readout_start;
    logic         readout_ready;
    word_t        readout_data;
    logic         readout_done;

    logic [31:0] lcg_state;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          cycle_count;
    int          done_pulses;
    int          done_cycle;
    int          fv_fall_cycle;
    int          exp_highlight;
    int          exp_shadow;
    pixel_t      frame_px [img_pixel_count];
    word_t       stored [img_pixel_count];
    word_t       expected_q [$];
    word_t       got_q [$];

    img_controller dut_i (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // One clock edge; capture_done pulses are counted here
    task automatic tick();
        @(posedge clk);
        cycle_count++;
        if (status_capture_done) begin
            done_pulses++;
            done_cycle = cycle_count;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ======================================================================
    // Sensor side
    // ======================================================================
    task automatic make_frame();
        logic [15:0] r;
        for (int i = 0; i < img_pixel_count; i++) begin
            r = next_rand();
            // Lean toward the extremes so highlights and shadows show up
            case (r[1:0])
                2'd0:    frame_px[i] = {7'h7f, r[6:2]};
                2'd1:    frame_px[i] = {7'h00, r[6:2]};
                default: frame_px[i] = r[15:4];
            endcase
        end
    endtask

    task automatic send_frame();
        int gap;
        img_fv <= 1'b1;
        repeat (4) tick();
        for (int row = 0; row < img_height; row++) begin
            for (int col = 0; col < img_width; col++) begin
                img_lv <= 1'b1;
                img_d  <= frame_px[row * img_width + col];
                tick();
            end
            img_lv <= 1'b0;
            img_d  <= pixel_t'(next_rand());
            gap = 1 + next_rand() % 4;
            repeat (gap) tick();
        end
        img_fv <= 1'b0;
        fv_fall_cycle = cycle_count;
        repeat (4) tick();
    endtask

    task automatic start_capture(input logic skip);
        cmd_capture    <= 1'b1;
        cmd_skip_count <= skip;
        tick();
        cmd_capture <= 1'b0;
        repeat (2) tick();
    endtask

    task automatic wait_capture(input int pulses_before);
        int n;
        n = 0;
        while (done_pulses == pulses_before && n < 8) begin
            tick();
            n++;
        end
        if (done_pulses != pulses_before + 1) begin
            $display("Capture gave %0d done pulses instead of one",
                     done_pulses - pulses_before);
            error_count++;
        end else if (done_cycle < fv_fall_cycle || done_cycle - fv_fall_cycle > 3) begin
            $display("Capture done came %0d cycles after the end of the frame",
                     done_cycle - fv_fall_cycle);
            error_count++;
        end
    endtask

    // Packed words and grid statistics of the captured frame
    task automatic model_capture();
        exp_highlight = 0;
        exp_shadow    = 0;
        for (int i = 0; i < img_pixel_count; i++) begin
            stored[i] = {frame_px[i][7:0], 4'h0, frame_px[i][11:8]};
            if ((i / img_width) % stat_sample_period == 0
                && (i % img_width) % stat_sample_period == 0) begin
                if (frame_px[i][11:5] == 7'h7f) exp_highlight++;
                else if (frame_px[i][11:5] == 7'h00) exp_shadow++;
            end
        end
    endtask

    task automatic check_status();
        compare("status_pixel_count", 32'(img_pixel_count), 32'(status_pixel_count));
        compare("status_highlight_count", 32'(exp_highlight), 32'(status_highlight_count));
        compare("status_shadow_count", 32'(exp_shadow), 32'(status_shadow_count));
    endtask

    // ======================================================================
    // Readout side
    // ======================================================================
    task automatic build_expected(input logic thumb, input header_t hdr);
        int    s1;
        int    s2;
        int    row;
        int    col;
        word_t w;
        expected_q.delete();
        for (int i = 0; i < header_word_count; i++)
            expected_q.push_back(hdr[(header_word_count - 1 - i) * 16 +: 16]);
        for (int i = 0; i < img_pixel_count; i++) begin
            row = i / img_width;
            col = i % img_width;
            if (!thumb || (col % thumb_group < thumb_keep && row % thumb_group < thumb_keep))
                expected_q.push_back(stored[i]);
        end
        // Fletcher-32 over byte swapped header and pixel words
        s1 = 0;
        s2 = 0;
        foreach (expected_q[k]) begin
            w  = {expected_q[k][7:0], expected_q[k][15:8]};
            s1 = (s1 + int'(w)) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        expected_q.push_back({s1[7:0], s1[15:8]});
        expected_q.push_back({s2[7:0], s2[15:8]});
        repeat (padding_word_count) expected_q.push_back(16'h0000);
    endtask

    task automatic run_readout(input logic thumb, input logic gaps);
        header_t hdr;
        int      n;
        int      start_at;
        int      done_at;
        for (int i = 0; i < header_word_count; i++)
            hdr[i * 16 +: 16] = next_rand();
        build_expected(thumb, hdr);
        got_q.delete();
        start_at = -1;
        done_at  = -1;
        n        = 0;
        cmd_header  <= hdr;
        cmd_thumb   <= thumb;
        cmd_readout <= 1'b1;
        while (done_at < 0 && n < 4 * readout_cycles) begin
            tick();
            n++;
            cmd_readout <= 1'b0;
            if (readout_start && start_at < 0) start_at = n;
            if (start_at >= 0 && readout_ready && readout_trigger)
                got_q.push_back(readout_data);
            if (start_at >= 0 && readout_done) done_at = got_q.size();
            readout_trigger <= gaps ? (next_rand() % 2 == 0) : 1'b1;
        end
        readout_trigger <= 1'b1;
        compare("readout_start cycle", 32'd2, 32'(start_at));
        if (done_at < 0) begin
            $display("Readout did not finish within %0d cycles", n);
            error_count++;
        end else if (done_at != expected_q.size()) begin
            $display("readout_done rose after %0d words instead of %0d",
                     done_at, expected_q.size());
            error_count++;
        end
        if (got_q.size() != expected_q.size()) begin
            $display("Readout gave %0d words where %0d were expected",
                     got_q.size(), expected_q.size());
            error_count++;
        end
        for (int i = 0; i < got_q.size() && i < expected_q.size(); i++)
            compare($sformatf("readout_data[%0d]", i), 32'(expected_q[i]), 32'(got_q[i]));
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int errs;
        int pulses;
        lcg_state    = 32'd18;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        done_pulses  = 0;
        done_cycle   = 0;
        reset           <= 1'b1;
        cmd_capture     <= 1'b0;
        cmd_skip_count  <= 1'b0;
        cmd_readout     <= 1'b0;
        cmd_header      <= '0;
        cmd_thumb       <= 1'b0;
        img_d           <= '0;
        img_fv          <= 1'b0;
        img_lv          <= 1'b0;
        readout_trigger <= 1'b1;
        repeat (8) tick();
        reset <= 1'b0;
        tick();

        errs = error_count;
        compare("readout_ready", 32'd0, 32'(readout_ready));
        compare("readout_done", 32'd0, 32'(readout_done));
        compare("readout_start", 32'd0, 32'(readout_start));
        compare("status_capture_done", 32'd0, 32'(status_capture_done));
        finish_test("test 1 reset values", errs);

        errs   = error_count;
        pulses = done_pulses;
        start_capture(1'b0);
        make_frame();
        send_frame();
        wait_capture(pulses);
        model_capture();
        check_status();
        run_readout(1'b0, 1'b0);
        finish_test("test 2 capture and full readout", errs);

        // First frame is skipped, second one is stored
        errs   = error_count;
        pulses = done_pulses;
        start_capture(1'b1);
        make_frame();
        send_frame();
        make_frame();
        send_frame();
        wait_capture(pulses);
        model_capture();
        check_status();
        run_readout(1'b0, 1'b0);
        finish_test("test 3 capture with one skipped frame", errs);

        errs = error_count;
        run_readout(1'b1, 1'b0);
        finish_test($sformatf("test 4 thumbnail readout of %0d pixel words",
                    expected_q.size() - header_word_count - checksum_word_count
                    - padding_word_count), errs);

        errs = error_count;
        run_readout(1'b0, 1'b1);
        finish_test("test 5 readout with trigger gaps", errs);

        $display("Tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* sim.f */
common/img_ctrl_pkg.sv
capture/pixel_capture.sv
hdl/frame_buffer.sv
hdl/fletcher_checksum.sv
readout/readout_sequencer.sv
hdl/img_controller.sv
testbench/tb_img_controller.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_img_controller
FILE_LIST = sim.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
